//--- project.f
core_pkg.sv
isa_pkg.sv
stage_cp.sv
reorder_buffer.sv
map_table.sv
complete_backend.sv
backend_tb.sv

//--- Bender.yml
package:
  name: complete_backend

sources:
  - core_pkg.sv
  - isa_pkg.sv
  - stage_cp.sv
  - reorder_buffer.sv
  - map_table.sv
  - complete_backend.sv
  - target: simulation
    files:
      - backend_tb.sv

//--- backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

module backend_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int rob_depth = default_rob_depth;
    localparam int tag_w     = $clog2(rob_depth);

    // phase lengths in cycles
    localparam int reset_cycles    = 8;
    localparam int sweep_cycles    = arch_regs;
    localparam int directed_cycles = 60;
    localparam int rounds          = 24;
    localparam int round_cycles    = 48;
    localparam int full_cycles     = 4 * rob_depth + 8;
    localparam int timeout_cycles  = 2 * (reset_cycles + sweep_cycles + directed_cycles
                                          + rounds * round_cycles + full_cycles);

    // one broadcast as the model sees it
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
        logic             branch;
    } cdb_t;

    //////////////////////////////
    // DUT signals
    //////////////////////////////

    logic clock = 1'b0;
    logic reset;
    logic             dispatch_valid;
    inst_kind_e       dispatch_kind;
    logic [reg_w-1:0] dispatch_reg;
    logic [tag_w-1:0] dispatch_tag;
    logic             rob_full;
    logic             ex_valid;
    logic             ex_done;
    logic [xlen-1:0]  ex_value;
    logic [tag_w-1:0] ex_tag;
    logic             ex_take_branch;
    logic             ex_rejected;
    logic             lsq_valid;
    logic             lsq_done;
    logic [xlen-1:0]  lsq_value;
    logic [tag_w-1:0] lsq_tag;
    logic             cdb_valid;
    logic [tag_w-1:0] cdb_tag;
    logic [xlen-1:0]  cdb_value;
    logic             cdb_take_branch;
    logic             commit_valid;
    logic [tag_w-1:0] commit_tag;
    inst_kind_e       commit_kind;
    logic [reg_w-1:0] commit_reg;
    logic [xlen-1:0]  commit_value;
    logic             commit_take_branch;
    logic [reg_w-1:0] lookup_reg;
    logic [tag_w-1:0] lookup_tag;
    logic             lookup_ready;

    // reference model state
    cdb_t             m_cdb;
    logic             m_rejected;
    rob_state_e       m_state [rob_depth];
    inst_kind_e       m_kind  [rob_depth];
    logic [reg_w-1:0] m_reg   [rob_depth];
    logic [xlen-1:0]  m_value [rob_depth];
    logic             m_taken [rob_depth];
    logic [tag_w-1:0] m_head;
    logic [tag_w-1:0] m_tail;
    int               m_count;
    logic             m_commit_valid;
    logic [tag_w-1:0] m_commit_tag;
    inst_kind_e       m_commit_kind;
    logic [reg_w-1:0] m_commit_reg;
    logic [xlen-1:0]  m_commit_value;
    logic             m_commit_taken;
    logic [tag_w-1:0] m_map_tag   [arch_regs];
    logic             m_map_ready [arch_regs];

    // stimulus bookkeeping
    logic [tag_w-1:0] pending [$];
    int               lookup_pin = 0;
    int               expected_commits = 0;
    int               commits_seen = 0;
    int               cycle_count = 0;

    always #2 clock = ~clock;

    complete_backend #(
        .rob_depth (rob_depth)
    ) dut (.*);

    ////////////////////////////// reference model

    // lsq first, then a finished ex result, else an all zero bus
    function automatic cdb_t arbitrate(
        input logic exv, input logic exd, input logic [xlen-1:0] exval,
        input logic [tag_w-1:0] extag, input logic exbr,
        input logic lv, input logic ld, input logic [xlen-1:0] lval,
        input logic [tag_w-1:0] ltag
    );
        cdb_t r;
        r = '0;
        if (lv && ld) begin
            r.valid = 1'b1;
            r.tag   = ltag;
            r.value = lval;
        end else if (exv && exd) begin
            r.valid  = 1'b1;
            r.tag    = extag;
            r.value  = exval;
            r.branch = exbr;
        end
        return r;
    endfunction

    task automatic reset_model();
        m_cdb          = '0;
        m_rejected     = 1'b0;
        m_commit_valid = 1'b0;
        m_head         = '0;
        m_tail         = '0;
        m_count        = 0;
        for (int i = 0; i < rob_depth; i++) begin
            m_state[i] = rob_empty;
        end
        // every register starts ready on tag 0
        for (int r = 0; r < arch_regs; r++) begin
            m_map_tag[r]   = '0;
            m_map_ready[r] = 1'b1;
        end
    endtask

    // inputs are stable at the edge, so the model reads them here
    always @(posedge clock) begin : model_update
        cdb_t nxt;
        logic accept;
        logic retire;
        nxt = arbitrate(ex_valid, ex_done, ex_value, ex_tag, ex_take_branch,
                        lsq_valid, lsq_done, lsq_value, lsq_tag);
        if (reset) begin
            reset_model();
        end else begin
            accept = dispatch_valid && (m_count < rob_depth);
            // head that was complete before this edge retires now
            retire = (m_state[m_head] == rob_complete);
            m_commit_valid = retire;
            if (retire) begin
                m_commit_tag   = m_head;
                m_commit_kind  = m_kind[m_head];
                m_commit_reg   = m_reg[m_head];
                m_commit_value = m_value[m_head];
                m_commit_taken = m_taken[m_head];
            end
            // bus contents of this cycle complete the entry and wake waiters
            if (m_cdb.valid) begin
                if (m_state[m_cdb.tag] == rob_issued) begin
                    m_state[m_cdb.tag] = rob_complete;
                    m_value[m_cdb.tag] = m_cdb.value;
                    m_taken[m_cdb.tag] = m_cdb.branch;
                end
                for (int r = 0; r < arch_regs; r++) begin
                    if (m_map_tag[r] == m_cdb.tag) begin
                        m_map_ready[r] = 1'b1;
                    end
                end
            end
            if (retire) begin
                m_state[m_head] = rob_empty;
                m_head          = m_head + 1'b1;
            end
            // rename after wakeup, so a same-edge dispatch stays not ready
            if (accept) begin
                m_state[m_tail] = rob_issued;
                m_kind[m_tail]  = dispatch_kind;
                m_reg[m_tail]   = dispatch_reg;
                if (dispatch_kind == kind_alu || dispatch_kind == kind_load) begin
                    m_map_tag[dispatch_reg]   = m_tail;
                    m_map_ready[dispatch_reg] = 1'b0;
                end
                m_tail = m_tail + 1'b1;
            end
            m_count    = m_count + int'(accept) - int'(retire);
            m_rejected = ex_valid && lsq_valid;
            m_cdb      = nxt;
        end
    end

    ////////////////////////////// compare tasks

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_cdb(
        input logic valid, input logic [tag_w-1:0] tag, input logic [xlen-1:0] value,
        input logic branch, input logic rejected, input cdb_t exp, input logic exp_rejected
    );
        if (valid !== exp.valid || tag !== exp.tag || value !== exp.value
                || branch !== exp.branch) begin
            $display("ERROR %0t: cdb got v=%b t=%0d d=%h b=%b, expected v=%b t=%0d d=%h b=%b",
                     $time, valid, tag, value, branch, exp.valid, exp.tag, exp.value,
                     exp.branch);
            abort_run();
        end else if (rejected !== exp_rejected) begin
            $display("ERROR %0t: ex_rejected got %b expected %b", $time, rejected, exp_rejected);
            abort_run();
        end
    endtask

    task automatic check_commit(
        input logic valid, input logic [tag_w-1:0] tag, input inst_kind_e kind,
        input logic [reg_w-1:0] rd, input logic [xlen-1:0] value, input logic taken,
        input logic exp_valid, input logic [tag_w-1:0] exp_tag, input inst_kind_e exp_kind,
        input logic [reg_w-1:0] exp_rd, input logic [xlen-1:0] exp_value, input logic exp_taken
    );
        if (valid !== exp_valid) begin
            $display("ERROR %0t: commit_valid got %b expected %b", $time, valid, exp_valid);
            abort_run();
        end else if (exp_valid && (tag !== exp_tag || kind !== exp_kind || rd !== exp_rd
                || value !== exp_value || taken !== exp_taken)) begin
            $display("ERROR %0t: commit got t=%0d k=%0d r=%0d d=%h b=%b, expected %0d %0d %0d %h %b",
                     $time, tag, kind, rd, value, taken, exp_tag, exp_kind, exp_rd, exp_value,
                     exp_taken);
            abort_run();
        end
    endtask

    task automatic check_lookup(
        input logic [reg_w-1:0] rd, input logic [tag_w-1:0] tag, input logic ready,
        input logic [tag_w-1:0] exp_tag, input logic exp_ready
    );
        if (tag !== exp_tag || ready !== exp_ready) begin
            $display("ERROR %0t: lookup r%0d got tag=%0d ready=%b, expected tag=%0d ready=%b",
                     $time, rd, tag, ready, exp_tag, exp_ready);
            abort_run();
        end
    endtask

    task automatic check_alloc(
        input logic [tag_w-1:0] tag, input logic full,
        input logic [tag_w-1:0] exp_tag, input logic exp_full
    );
        if (tag !== exp_tag || full !== exp_full) begin
            $display("ERROR %0t: dispatch_tag=%0d rob_full=%b, expected %0d %b",
                     $time, tag, full, exp_tag, exp_full);
            abort_run();
        end
    endtask

    // mid cycle, well away from the edge and the input drive point
    always @(negedge clock) begin
        check_cdb(cdb_valid, cdb_tag, cdb_value, cdb_take_branch, ex_rejected,
                  m_cdb, m_rejected);
        check_commit(commit_valid, commit_tag, commit_kind, commit_reg, commit_value,
                     commit_take_branch, m_commit_valid, m_commit_tag, m_commit_kind,
                     m_commit_reg, m_commit_value, m_commit_taken);
        check_lookup(lookup_reg, lookup_tag, lookup_ready,
                     m_map_tag[lookup_reg], m_map_ready[lookup_reg]);
        check_alloc(dispatch_tag, rob_full, m_tail, m_count == rob_depth);
        if (commit_valid === 1'b1) begin
            commits_seen++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run was still busy after %0d cycles", cycle_count);
            abort_run();
        end
    end

    ////////////////////////////// stimulus helpers

    task automatic idle_inputs();
        dispatch_valid = 1'b0;
        dispatch_kind  = kind_alu;
        dispatch_reg   = '0;
        ex_valid       = 1'b0;
        ex_done        = 1'b0;
        ex_value       = '0;
        ex_tag         = '0;
        ex_take_branch = 1'b0;
        lsq_valid      = 1'b0;
        lsq_done       = 1'b0;
        lsq_value      = '0;
        lsq_tag        = '0;
        lookup_reg     = '0;
    endtask

    // pinned lookup register, or a random one when the pin is negative
    task automatic step();
        if (lookup_pin >= 0) begin
            lookup_reg = reg_w'(lookup_pin);
        end else begin
            lookup_reg = reg_w'($urandom_range(arch_regs - 1, 0));
        end
        @(posedge clock);
        #0.5;
        dispatch_valid = 1'b0;
        ex_valid       = 1'b0;
        ex_done        = 1'b0;
        lsq_valid      = 1'b0;
        lsq_done       = 1'b0;
    endtask

    task automatic drive_ex(input logic [tag_w-1:0] tag, input logic [xlen-1:0] value,
                            input logic taken, input logic done);
        ex_valid       = 1'b1;
        ex_done        = done;
        ex_tag         = tag;
        ex_value       = value;
        ex_take_branch = taken;
    endtask

    task automatic drive_lsq(input logic [tag_w-1:0] tag, input logic [xlen-1:0] value,
                             input logic done);
        lsq_valid = 1'b1;
        lsq_done  = done;
        lsq_tag   = tag;
        lsq_value = value;
    endtask

    task automatic dispatch_op(input inst_kind_e kind, input int rd,
                               output logic [tag_w-1:0] tag);
        tag = m_tail;
        // a full ROB drops it, so nothing will commit
        if (m_count < rob_depth) begin
            expected_commits++;
        end
        dispatch_valid = 1'b1;
        dispatch_kind  = kind;
        dispatch_reg   = reg_w'(rd);
        step();
    endtask

    task automatic dispatch_batch(input int n);
        logic [tag_w-1:0] t;
        for (int i = 0; i < n; i++) begin
            if (m_count < rob_depth) begin
                pending.push_back(m_tail);
            end
            dispatch_op(inst_kind_e'($urandom_range(3, 0)), $urandom_range(arch_regs - 1, 0), t);
        end
    endtask

    // finish every pending tag in random order over random ports
    task automatic complete_all();
        int               idx;
        logic             ex_busy;
        logic [tag_w-1:0] ex_t;
        logic [xlen-1:0]  ex_v;
        logic             ex_b;
        ex_busy = 1'b0;
        while (pending.size() != 0 || ex_busy) begin
            // ex result went through unless it was just turned away
            if (ex_busy && !ex_rejected) begin
                ex_busy = 1'b0;
            end
            if (!ex_busy && pending.size() != 0 && $urandom_range(1, 0) == 1) begin
                idx = $urandom_range(pending.size() - 1, 0);
                ex_t = pending[idx];
                pending.delete(idx);
                ex_v = {$urandom, $urandom};
                ex_b = 1'($urandom_range(1, 0));
                ex_busy = 1'b1;
            end
            if (ex_busy) begin
                drive_ex(ex_t, ex_v, ex_b, 1'b1);
            end
            if (pending.size() != 0 && $urandom_range(1, 0) == 1) begin
                idx = $urandom_range(pending.size() - 1, 0);
                drive_lsq(pending[idx], {$urandom, $urandom}, 1'b1);
                pending.delete(idx);
            end
            step();
        end
    endtask

    // commit_valid is the only end marker, the global timeout bounds it
    task automatic wait_commits();
        while (commits_seen < expected_commits) begin
            step();
        end
    endtask

    ////////////////////////////// test sequence

    initial begin
        logic [tag_w-1:0] t_a;
        logic [tag_w-1:0] t_b;
        logic [tag_w-1:0] t_c;
        logic [tag_w-1:0] t_d;
        void'($urandom(7765));
        reset = 1'b1;
        idle_inputs();
        repeat (reset_cycles) @(posedge clock);
        #0.5;
        reset = 1'b0;

        // every register ready on tag 0 after reset
        for (int r = 0; r < arch_regs; r++) begin
            lookup_pin = r;
            step();
        end

        // both ports valid but not done, bus idle, ex still rejected
        lookup_pin = 1;
        dispatch_op(kind_alu, 1, t_a);
        dispatch_op(kind_branch, 0, t_b);
        drive_ex(t_b, 64'h0000_0000_0bad_0001, 1'b1, 1'b0);
        drive_lsq(t_a, 64'h0000_0000_0bad_0002, 1'b0);
        step();
        // both done, lsq wins
        drive_ex(t_b, 64'h1111_2222_3333_4444, 1'b1, 1'b1);
        drive_lsq(t_a, 64'h5555_6666_7777_8888, 1'b1);
        step();
        // rejected ex result comes back alone with its branch flag
        drive_ex(t_b, 64'h1111_2222_3333_4444, 1'b1, 1'b1);
        step();
        wait_commits();

        // r5 renamed twice, r6 only seen by store and branch
        lookup_pin = 5;
        dispatch_op(kind_alu, 5, t_a);
        dispatch_op(kind_load, 5, t_b);
        lookup_pin = 6;
        dispatch_op(kind_store, 6, t_c);
        dispatch_op(kind_branch, 6, t_d);
        // older producer done, r5 still waits
        drive_lsq(t_a, 64'h0000_0000_0000_00a5, 1'b1);
        // r6 looked at once more after the branch went in
        step();
        lookup_pin = 5;
        repeat (2) step();
        drive_ex(t_b, 64'h0000_0000_0000_00b5, 1'b0, 1'b1);
        repeat (2) step();
        drive_ex(t_d, 64'h0000_0000_0000_00d6, 1'b1, 1'b1);
        step();
        drive_lsq(t_c, 64'h0000_0000_0000_00c6, 1'b1);
        step();
        wait_commits();

        // random batches completed out of order
        lookup_pin = -1;
        for (int r = 0; r < rounds; r++) begin
            dispatch_batch($urandom_range(8, 1));
            complete_all();
            wait_commits();
        end

        // fill the ROB, then one more dispatch that must be dropped
        dispatch_batch(rob_depth);
        lookup_pin = 9;
        dispatch_op(kind_alu, 9, t_a);
        // r9 and the tail seen again after the dropped dispatch
        step();
        lookup_pin = -1;
        complete_all();
        wait_commits();
        repeat (4) step();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- complete_backend.sv
`timescale 1ns/100ps
`default_nettype none

module complete_backend #(
    parameter int rob_depth = core_pkg::default_rob_depth
) (
    input  logic                          clock,
    input  logic                          reset,
    // dispatch
    input  logic                          dispatch_valid,
    input  isa_pkg::inst_kind_e           dispatch_kind,
    input  logic [isa_pkg::reg_w-1:0]     dispatch_reg,
    output logic [$clog2(rob_depth)-1:0]  dispatch_tag,
    output logic                          rob_full,
    // ALU / branch results
    input  logic                          ex_valid,
    input  logic                          ex_done,
    input  logic [isa_pkg::xlen-1:0]      ex_value,
    input  logic [$clog2(rob_depth)-1:0]  ex_tag,
    input  logic                          ex_take_branch,
    output logic                          ex_rejected,
    // load/store results
    input  logic                          lsq_valid,
    input  logic                          lsq_done,
    input  logic [isa_pkg::xlen-1:0]      lsq_value,
    input  logic [$clog2(rob_depth)-1:0]  lsq_tag,
    // CDB, also fed back into the ROB and map table
    output logic                          cdb_valid,
    output logic [$clog2(rob_depth)-1:0]  cdb_tag,
    output logic [isa_pkg::xlen-1:0]      cdb_value,
    output logic                          cdb_take_branch,
    // retirement
    output logic                          commit_valid,
    output logic [$clog2(rob_depth)-1:0]  commit_tag,
    output isa_pkg::inst_kind_e           commit_kind,
    output logic [isa_pkg::reg_w-1:0]     commit_reg,
    output logic [isa_pkg::xlen-1:0]      commit_value,
    output logic                          commit_take_branch,
    // operand lookup
    input  logic [isa_pkg::reg_w-1:0]     lookup_reg,
    output logic [$clog2(rob_depth)-1:0]  lookup_tag,
    output logic                          lookup_ready
);

    //////////////////////////////
    // result arbiter
    //////////////////////////////

    stage_cp #(
        .rob_depth (rob_depth)
    ) u_stage_cp (
        .clock           (clock),
        .reset           (reset),
        .ex_valid        (ex_valid),
        .ex_done         (ex_done),
        .ex_value        (ex_value),
        .ex_tag          (ex_tag),
        .ex_take_branch  (ex_take_branch),
        .lsq_valid       (lsq_valid),
        .lsq_done        (lsq_done),
        .lsq_value       (lsq_value),
        .lsq_tag         (lsq_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_take_branch (cdb_take_branch),
        .ex_rejected     (ex_rejected)
    );

    //////////////////////////////
    // reorder buffer
    //////////////////////////////

    reorder_buffer #(
        .rob_depth (rob_depth)
    ) u_rob (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dispatch_kind      (dispatch_kind),
        .dispatch_reg       (dispatch_reg),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value),
        .cdb_take_branch    (cdb_take_branch),
        .dispatch_tag       (dispatch_tag),
        .rob_full           (rob_full),
        .commit_valid       (commit_valid),
        .commit_tag         (commit_tag),
        .commit_kind        (commit_kind),
        .commit_reg         (commit_reg),
        .commit_value       (commit_value),
        .commit_take_branch (commit_take_branch)
    );

    //////////////////////////////
    // rename map
    //////////////////////////////

    // sees the same dispatch and tag the ROB hands out
    map_table #(
        .rob_depth (rob_depth)
    ) u_map_table (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_kind  (dispatch_kind),
        .dispatch_reg   (dispatch_reg),
        .dispatch_tag   (dispatch_tag),
        .rob_full       (rob_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .lookup_reg     (lookup_reg),
        .lookup_tag     (lookup_tag),
        .lookup_ready   (lookup_ready)
    );

endmodule

`default_nettype wire

//--- map_table.sv
`timescale 1ns/100ps
`default_nettype none

module map_table #(
    parameter int rob_depth = core_pkg::default_rob_depth
) (
    input  logic                          clock,
    input  logic                          reset,
    // dispatch as seen by the ROB
    input  logic                          dispatch_valid,
    input  isa_pkg::inst_kind_e           dispatch_kind,
    input  logic [isa_pkg::reg_w-1:0]     dispatch_reg,
    input  logic [$clog2(rob_depth)-1:0]  dispatch_tag,
    input  logic                          rob_full,
    // broadcast side
    input  logic                          cdb_valid,
    input  logic [$clog2(rob_depth)-1:0]  cdb_tag,
    // operand lookup
    input  logic [isa_pkg::reg_w-1:0]     lookup_reg,
    output logic [$clog2(rob_depth)-1:0]  lookup_tag,
    output logic                          lookup_ready
);
    import isa_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    // newest producer of each register and whether its value is out
    logic [tag_w-1:0]     tag_q [arch_regs];
    logic [arch_regs-1:0] ready_q;

    logic                 writes_reg;
    logic                 do_rename;

    //////////////////////////////
    // rename decision
    //////////////////////////////

    // stores and branches have no destination
    assign writes_reg = (dispatch_kind == kind_alu) || (dispatch_kind == kind_load);

    // a dispatch the ROB drops must not touch the map
    assign do_rename = dispatch_valid && !rob_full && writes_reg;

    //////////////////////////////
    // table update
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_regs; r++) begin
                tag_q[r] <= '0;
            end
            ready_q <= '1;
        end else begin
            // wake every register still waiting on the broadcast tag
            // an older producer no longer matches once renamed
            if (cdb_valid) begin
                for (int r = 0; r < arch_regs; r++) begin
                    if (tag_q[r] == cdb_tag) begin
                        ready_q[r] <= 1'b1;
                    end
                end
            end

            // later assignment wins, same-edge rename stays not ready
            if (do_rename) begin
                tag_q[dispatch_reg]   <= dispatch_tag;
                ready_q[dispatch_reg] <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // lookup
    //////////////////////////////

    assign lookup_tag   = tag_q[lookup_reg];
    assign lookup_ready = ready_q[lookup_reg];

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int rob_depth = core_pkg::default_rob_depth
) (
    input  logic                          clock,
    input  logic                          reset,
    // allocation side
    input  logic                          dispatch_valid,
    input  isa_pkg::inst_kind_e           dispatch_kind,
    input  logic [isa_pkg::reg_w-1:0]     dispatch_reg,
    // completion side, straight off the CDB
    input  logic                          cdb_valid,
    input  logic [$clog2(rob_depth)-1:0]  cdb_tag,
    input  logic [isa_pkg::xlen-1:0]      cdb_value,
    input  logic                          cdb_take_branch,
    // tag handed to the instruction being dispatched
    output logic [$clog2(rob_depth)-1:0]  dispatch_tag,
    output logic                          rob_full,
    // retirement port
    output logic                          commit_valid,
    output logic [$clog2(rob_depth)-1:0]  commit_tag,
    output isa_pkg::inst_kind_e           commit_kind,
    output logic [isa_pkg::reg_w-1:0]     commit_reg,
    output logic [isa_pkg::xlen-1:0]      commit_value,
    output logic                          commit_take_branch
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    // per entry state and payload
    rob_state_e         state_q  [rob_depth];
    inst_kind_e         kind_q   [rob_depth];
    logic [reg_w-1:0]   reg_q    [rob_depth];
    logic [xlen-1:0]    value_q  [rob_depth];
    logic               branch_q [rob_depth];

    // circular pointers, one extra count bit to tell full from empty
    logic [tag_w-1:0]   head;
    logic [tag_w-1:0]   tail;
    logic [tag_w:0]     count;

    logic               do_dispatch;
    logic               do_complete;
    logic               do_retire;

    //////////////////////////////
    // status and strobes
    //////////////////////////////

    assign dispatch_tag = tail;

    // count tops out at rob_depth, which is the only value with the msb set
    assign rob_full = count[tag_w];

    // dispatch while full is dropped
    assign do_dispatch = dispatch_valid && !rob_full;

    // only a waiting entry takes a broadcast
    // a stray tag aimed at a free slot is ignored
    assign do_complete = cdb_valid && (state_q[cdb_tag] == rob_issued);

    // head leaves as soon as its result is in
    assign do_retire = (state_q[head] == rob_complete);

    //////////////////////////////
    // control state
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rob_depth; i++) begin
                state_q[i] <= rob_empty;
            end
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= do_retire;

            if (do_complete) begin
                state_q[cdb_tag] <= rob_complete;
            end

            // retire frees the head slot and moves on
            if (do_retire) begin
                state_q[head] <= rob_empty;
                head          <= head + 1'b1;
            end

            // tail slot is always free when not full
            if (do_dispatch) begin
                state_q[tail] <= rob_issued;
                tail          <= tail + 1'b1;
            end

            // occupancy, unchanged when both or neither happen
            case ({do_dispatch, do_retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////
    // payload and commit outputs
    //////////////////////////////

    always_ff @(posedge clock) begin
        // what the instruction is and where it writes
        if (do_dispatch) begin
            kind_q[tail] <= dispatch_kind;
            reg_q[tail]  <= dispatch_reg;
        end

        // result and branch outcome arrive later from the CDB
        if (do_complete) begin
            value_q[cdb_tag]  <= cdb_value;
            branch_q[cdb_tag] <= cdb_take_branch;
        end

        // fields only meaningful while commit_valid is high
        if (do_retire) begin
            commit_tag         <= head;
            commit_kind        <= kind_q[head];
            commit_reg         <= reg_q[head];
            commit_value       <= value_q[head];
            commit_take_branch <= branch_q[head];
        end
    end

endmodule

`default_nettype wire

//--- stage_cp.sv
`timescale 1ns/100ps
`default_nettype none

module stage_cp #(
    parameter int rob_depth = core_pkg::default_rob_depth
) (
    input  logic                          clock,
    input  logic                          reset,
    // result port from the ALU / branch unit
    input  logic                          ex_valid,
    input  logic                          ex_done,
    input  logic [isa_pkg::xlen-1:0]      ex_value,
    input  logic [$clog2(rob_depth)-1:0]  ex_tag,
    input  logic                          ex_take_branch,
    // result port from the load/store queue
    input  logic                          lsq_valid,
    input  logic                          lsq_done,
    input  logic [isa_pkg::xlen-1:0]      lsq_value,
    input  logic [$clog2(rob_depth)-1:0]  lsq_tag,
    // common data bus
    output logic                          cdb_valid,
    output logic [$clog2(rob_depth)-1:0]  cdb_tag,
    output logic [isa_pkg::xlen-1:0]      cdb_value,
    output logic                          cdb_take_branch,
    output logic                          ex_rejected
);
    import isa_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    logic               lsq_wins;
    logic               ex_wins;
    logic               next_valid;
    logic [tag_w-1:0]   next_tag;
    logic [xlen-1:0]    next_value;
    logic               next_branch;

    //////////////////////////////
    // winner select
    //////////////////////////////

    // lsq has fixed priority, it is never turned away
    assign lsq_wins = lsq_valid && lsq_done;
    assign ex_wins  = !lsq_wins && ex_valid && ex_done;

    always_comb begin
        next_valid  = lsq_wins || ex_wins;
        next_tag    = '0;
        next_value  = {xlen{1'b0}};
        next_branch = 1'b0;
        if (lsq_wins) begin
            // memory ops never redirect fetch
            next_tag   = lsq_tag;
            next_value = lsq_value;
        end else if (ex_wins) begin
            next_tag    = ex_tag;
            next_value  = ex_value;
            next_branch = ex_take_branch;
        end
    end

    //////////////////////////////
    // broadcast register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid       <= 1'b0;
            cdb_tag         <= '0;
            cdb_value       <= {xlen{1'b0}};
            cdb_take_branch <= 1'b0;
            ex_rejected     <= 1'b0;
        end else begin
            // idle cycles leave the bus all zero
            cdb_valid       <= next_valid;
            cdb_tag         <= next_tag;
            cdb_value       <= next_value;
            cdb_take_branch <= next_branch;
            // based on valid only, so ex resends even if lsq was not done
            ex_rejected     <= ex_valid && lsq_valid;
        end
    end

endmodule

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

    //////////////////////////////
    // datapath and register file
    //////////////////////////////

    // width of a result value carried on the CDB
    localparam int xlen = 64;

    // architectural registers visible to software
    localparam int arch_regs = 32;

    // bits needed to name one architectural register
    localparam int reg_w = $clog2(arch_regs);

    //////////////////////////////
    // instruction kinds
    //////////////////////////////

    // recorded at dispatch and carried to commit
    // stores and branches have no destination register
    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_load   = 2'd1,
        kind_store  = 2'd2,
        kind_branch = 2'd3
    } inst_kind_e;

endpackage

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

    //////////////////////////////
    // reorder buffer sizing
    //////////////////////////////

    // entries in the ROB unless the top level overrides it
    // must stay a power of two, at least 4, so head and tail wrap for free
    localparam int default_rob_depth = 16;

    //////////////////////////////
    // reorder buffer entry state
    //////////////////////////////

    // lifecycle of one ROB slot
    // empty     slot is free, head or tail may point at it
    // issued    allocated at dispatch, waiting for its CDB broadcast
    // complete  result captured, waiting to reach the head
    typedef enum logic [1:0] {
        rob_empty    = 2'd0,
        rob_issued   = 2'd1,
        rob_complete = 2'd2
    } rob_state_e;

endpackage

`default_nettype wire
